// File: files.f
+incdir+hw
hw/mesh_pkg.sv
hw/mesh_link_if.sv
hw/mesh_router.sv
hw/mesh_master.sv
hw/mesh_slave.sv
hw/mesh_top.sv
sim/mesh_tb.sv

// File: hw/mesh_defs.svh
`ifndef MESH_DEFS_SVH
`define MESH_DEFS_SVH

// ==========================================================
// network geometry
// ==========================================================
`define MESH_X_W 2
`define MESH_Y_W 2

// ==========================================================
// payload and memory
// ==========================================================
`define MESH_ADDR_W 8
`define MESH_DATA_W 32

// words held by the slave
`define MESH_SLAVE_DEPTH 16
// words written and read back per run
`define MESH_RUN_WORDS 8

`endif

// File: hw/mesh_link_if.sv
`timescale 1ns/1ps

interface mesh_link_if import mesh_pkg::*; ();

  // router to client direction
  mesh_packet_t rtr_pkt;
  logic         rtr_v;
  logic         rtr_rdy;

  // client to router direction
  mesh_packet_t cli_pkt;
  logic         cli_v;
  logic         cli_rdy;

  modport router (
    output rtr_pkt,
    output rtr_v,
    input  rtr_rdy,
    input  cli_pkt,
    input  cli_v,
    output cli_rdy
  );

  modport client (
    input  rtr_pkt,
    input  rtr_v,
    output rtr_rdy,
    output cli_pkt,
    output cli_v,
    input  cli_rdy
  );

endinterface

// File: hw/mesh_master.sv
`timescale 1ns/1ps
`include "mesh_defs.svh"

module mesh_master import mesh_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  mesh_link_if.client link,
  input  x_cord_t     my_x_i,
  input  y_cord_t     my_y_i,
  input  x_cord_t     dest_x_i,
  input  y_cord_t     dest_y_i,
  input  logic        start_i,
  input  data_t       seed_i,
  output logic        reply_v_o,
  output addr_t       reply_addr_o,
  output data_t       reply_data_o,
  output logic        finish_o
);

  localparam int RUN   = `MESH_RUN_WORDS;
  localparam int ISS_W = $clog2(2 * RUN + 1);
  localparam int REP_W = $clog2(RUN + 1);

  master_state_e    state_q, state_d;
  logic [ISS_W-1:0] issue_cnt_q;
  logic [REP_W-1:0] reply_cnt_q;
  logic [ISS_W-1:0] loads_sent;
  data_t            seed_q;
  logic             launch, tx_fire, rep_fire;

  assign launch   = start_i && (state_q == IDLE || state_q == DONE);
  assign tx_fire  = link.cli_v && link.cli_rdy;
  assign rep_fire = link.rtr_v && link.rtr_pkt.op == OP_REPLY;

  // ==========================================================
  // request side
  // ==========================================================
  always_comb begin
    link.cli_v         = (state_q == STORE) || (state_q == LOAD);
    link.cli_pkt       = '0;
    link.cli_pkt.dst_x = dest_x_i;
    link.cli_pkt.dst_y = dest_y_i;
    link.cli_pkt.src_x = my_x_i;
    link.cli_pkt.src_y = my_y_i;
    if (state_q == LOAD) begin
      link.cli_pkt.op   = OP_LOAD;
      link.cli_pkt.addr = addr_t'(issue_cnt_q - ISS_W'(RUN));
    end else begin
      link.cli_pkt.op   = OP_STORE;
      link.cli_pkt.addr = addr_t'(issue_cnt_q);
      link.cli_pkt.data = seed_q + data_t'(issue_cnt_q);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE:
        if (start_i)
          state_d = STORE;
      STORE:
        if (tx_fire && issue_cnt_q == ISS_W'(RUN - 1))
          state_d = LOAD;
      LOAD:
        if (tx_fire && issue_cnt_q == ISS_W'(2 * RUN - 1))
          state_d = WAIT;
      WAIT:
        if (reply_cnt_q == REP_W'(RUN))
          state_d = DONE;
      default:
        state_d = IDLE;
    endcase
  end

  // ==========================================================
  // counters and reply reporting
  // ==========================================================
  // replies are always taken
  assign link.rtr_rdy = 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      issue_cnt_q <= '0;
      reply_cnt_q <= '0;
      reply_v_o   <= 1'b0;
    end else begin
      state_q   <= state_d;
      reply_v_o <= rep_fire;
      if (launch) begin
        issue_cnt_q <= '0;
        reply_cnt_q <= '0;
      end else begin
        if (tx_fire)
          issue_cnt_q <= issue_cnt_q + 1'b1;
        if (rep_fire)
          reply_cnt_q <= reply_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch)
      seed_q <= seed_i;
    if (rep_fire) begin
      reply_addr_o <= link.rtr_pkt.addr;
      reply_data_o <= link.rtr_pkt.data;
    end
  end

  assign finish_o = (state_q == DONE);

  // loads issued so far, from the shared issue count
  assign loads_sent = (issue_cnt_q > ISS_W'(RUN)) ? issue_cnt_q - ISS_W'(RUN) : '0;

  a_reply_le_load: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rep_fire |-> ISS_W'(reply_cnt_q) < loads_sent)
    else $error("reply arrived with no load outstanding");

endmodule

// File: hw/mesh_pkg.sv
`include "mesh_defs.svh"

package mesh_pkg;

  // ==========================================================
  // vectors with a meaning
  // ==========================================================
  typedef logic [`MESH_X_W-1:0]    x_cord_t;
  typedef logic [`MESH_Y_W-1:0]    y_cord_t;
  typedef logic [`MESH_ADDR_W-1:0] addr_t;
  typedef logic [`MESH_DATA_W-1:0] data_t;

  // ==========================================================
  // packet format
  // ==========================================================
  typedef enum logic [1:0] {OP_STORE, OP_LOAD, OP_REPLY} opcode_t;

  // one flit carries the whole request or reply
  typedef struct packed {
    opcode_t op;
    x_cord_t dst_x;
    y_cord_t dst_y;
    x_cord_t src_x;
    y_cord_t src_y;
    addr_t   addr;
    data_t   data;
  } mesh_packet_t;

  // router port index, processor port first
  typedef enum logic [2:0] {P = 3'd0, W, E, N, S} dir_e;

  // issue side of the master
  typedef enum logic [2:0] {IDLE, STORE, LOAD, WAIT, DONE} master_state_e;

endpackage

// File: hw/mesh_router.sv
`timescale 1ns/1ps

module mesh_router import mesh_pkg::*; #(
  parameter logic [4:0] stub_p = 5'b00000
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  mesh_link_if.router       links [4],
  mesh_link_if.router       proc_link,
  input  x_cord_t           my_x_i,
  input  y_cord_t           my_y_i
);

  // X first, then Y, then local delivery
  function automatic dir_e route_dir(input mesh_packet_t pkt, input x_cord_t x,
                                     input y_cord_t y);
    if (pkt.dst_x < x) return W;
    if (pkt.dst_x > x) return E;
    if (pkt.dst_y < y) return N;
    if (pkt.dst_y > y) return S;
    return P;
  endfunction

  // first requester after the last grant wins
  function automatic logic [2:0] rr_pick(input logic [4:0] req, input logic [2:0] last);
    logic [2:0] pick;
    int         idx;
    pick = last;
    for (int k = 5; k >= 1; k--) begin
      idx = (int'(last) + k) % 5;
      if (req[idx])
        pick = 3'(idx);
    end
    return pick;
  endfunction

  wire  [4:0]   rx_v;
  wire  mesh_packet_t rx_pkt [5];
  logic [4:0]   rx_rdy;
  logic [4:0]   tx_v;
  mesh_packet_t tx_pkt [5];
  wire  [4:0]   tx_rdy;

  logic [4:0]   buf_v_q;
  mesh_packet_t buf_pkt_q [5];
  logic [4:0]   req [5];
  logic [2:0]   sel [5];
  logic [2:0]   last_q [5];
  logic [4:0]   lock_q;
  logic [4:0]   drain;

  // ==========================================================
  // port hookup and tie-off of stubbed ports
  // ==========================================================
  if (stub_p[P]) begin : g_proc_stub
    assign proc_link.rtr_v   = 1'b0;
    assign proc_link.rtr_pkt = '0;
    assign proc_link.cli_rdy = 1'b1;
    assign rx_v[P]   = 1'b0;
    assign rx_pkt[P] = '0;
    assign tx_rdy[P] = 1'b1;
    a_proc_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !proc_link.cli_v)
      else $error("packet dropped on stubbed processor port");
  end else begin : g_proc_live
    assign proc_link.rtr_v   = tx_v[P];
    assign proc_link.rtr_pkt = tx_pkt[P];
    assign proc_link.cli_rdy = rx_rdy[P];
    assign rx_v[P]   = proc_link.cli_v;
    assign rx_pkt[P] = proc_link.cli_pkt;
    assign tx_rdy[P] = proc_link.rtr_rdy;
  end

  // links[0..3] hold W, E, N, S
  for (genvar d = 1; d < 5; d++) begin : g_port
    if (stub_p[d]) begin : g_stub
      assign links[d-1].rtr_v   = 1'b0;
      assign links[d-1].rtr_pkt = '0;
      assign links[d-1].cli_rdy = 1'b1;
      assign rx_v[d]   = 1'b0;
      assign rx_pkt[d] = '0;
      assign tx_rdy[d] = 1'b1;
      a_stub_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !links[d-1].cli_v)
        else $error("packet dropped on stubbed port %0d", d);
    end else begin : g_live
      assign links[d-1].rtr_v   = tx_v[d];
      assign links[d-1].rtr_pkt = tx_pkt[d];
      assign links[d-1].cli_rdy = rx_rdy[d];
      assign rx_v[d]   = links[d-1].cli_v;
      assign rx_pkt[d] = links[d-1].cli_pkt;
      assign tx_rdy[d] = links[d-1].rtr_rdy;
    end
  end

  // ==========================================================
  // input buffers and output arbitration
  // ==========================================================
  assign rx_rdy = ~buf_v_q;

  always_comb begin
    drain = '0;
    for (int o = 0; o < 5; o++) begin
      for (int i = 0; i < 5; i++) begin
        req[o][i] = buf_v_q[i] && (int'(route_dir(buf_pkt_q[i], my_x_i, my_y_i)) == o);
      end
      // a stalled grant stays put so the packet holds
      sel[o]    = lock_q[o] ? last_q[o] : rr_pick(req[o], last_q[o]);
      tx_v[o]   = |req[o];
      tx_pkt[o] = buf_pkt_q[sel[o]];
      if (tx_v[o] && tx_rdy[o])
        drain[sel[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_v_q <= '0;
      lock_q  <= '0;
      for (int o = 0; o < 5; o++)
        last_q[o] <= '0;
    end else begin
      buf_v_q <= (buf_v_q & ~drain) | (rx_v & rx_rdy);
      for (int o = 0; o < 5; o++) begin
        if (tx_v[o]) begin
          last_q[o] <= sel[o];
          lock_q[o] <= !tx_rdy[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 5; i++) begin
      if (rx_v[i] && rx_rdy[i])
        buf_pkt_q[i] <= rx_pkt[i];
    end
  end

  for (genvar o = 0; o < 5; o++) begin : g_chk
    a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tx_v[o] && !tx_rdy[o] |=> tx_v[o] && $stable(tx_pkt[o]))
      else $error("output %0d dropped or changed a stalled packet", o);
  end

endmodule

// File: hw/mesh_slave.sv
`timescale 1ns/1ps
`include "mesh_defs.svh"

module mesh_slave import mesh_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  mesh_link_if.client link,
  input  x_cord_t     my_x_i,
  input  y_cord_t     my_y_i
);

  localparam int DEPTH = `MESH_SLAVE_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);

  data_t            mem_q [DEPTH];
  logic [IDX_W-1:0] idx;
  logic             rx_fire;
  logic             rep_v_q;
  mesh_packet_t     rep_pkt_q;
  mesh_packet_t     reply;

  // ==========================================================
  // request intake
  // ==========================================================
  // take a request only when the reply slot frees up
  assign link.rtr_rdy = !rep_v_q || link.cli_rdy;
  assign rx_fire      = link.rtr_v && link.rtr_rdy;
  assign idx          = link.rtr_pkt.addr[IDX_W-1:0];

  always_comb begin
    reply       = '0;
    reply.op    = OP_REPLY;
    reply.dst_x = link.rtr_pkt.src_x;
    reply.dst_y = link.rtr_pkt.src_y;
    reply.src_x = my_x_i;
    reply.src_y = my_y_i;
    reply.addr  = link.rtr_pkt.addr;
    reply.data  = mem_q[idx];
  end

  always_ff @(posedge clk_i) begin
    if (rx_fire && link.rtr_pkt.op == OP_STORE)
      mem_q[idx] <= link.rtr_pkt.data;
    if (rx_fire && link.rtr_pkt.op == OP_LOAD)
      rep_pkt_q <= reply;
  end

  // ==========================================================
  // reply slot
  // ==========================================================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rep_v_q <= 1'b0;
    end else if (rx_fire && link.rtr_pkt.op == OP_LOAD) begin
      rep_v_q <= 1'b1;
    end else if (link.cli_rdy) begin
      rep_v_q <= 1'b0;
    end
  end

  assign link.cli_v   = rep_v_q;
  assign link.cli_pkt = rep_pkt_q;

  // misrouted traffic would show up here
  a_own_dest: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rx_fire |-> link.rtr_pkt.dst_x == my_x_i && link.rtr_pkt.dst_y == my_y_i)
    else $error("slave received a packet for another node");

endmodule

// File: hw/mesh_top.sv
`timescale 1ns/1ps

module mesh_top import mesh_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  start_i,
  input  data_t seed_i,
  output logic  reply_v_o,
  output addr_t reply_addr_o,
  output data_t reply_data_o,
  output logic  finish_o
);

  // ==========================================================
  // links, one array per router plus processor ports
  // ==========================================================
  mesh_link_if r0_links [4] ();
  mesh_link_if r1_links [4] ();
  mesh_link_if p0_link ();
  mesh_link_if p1_link ();

  // node 0 east to node 1 west
  assign r1_links[W-1].cli_pkt = r0_links[E-1].rtr_pkt;
  assign r1_links[W-1].cli_v   = r0_links[E-1].rtr_v;
  assign r0_links[E-1].rtr_rdy = r1_links[W-1].cli_rdy;
  assign r0_links[E-1].cli_pkt = r1_links[W-1].rtr_pkt;
  assign r0_links[E-1].cli_v   = r1_links[W-1].rtr_v;
  assign r1_links[W-1].rtr_rdy = r0_links[E-1].cli_rdy;

  // nothing attached on the stubbed sides
  assign r0_links[W-1].cli_v = 1'b0;
  assign r0_links[N-1].cli_v = 1'b0;
  assign r0_links[S-1].cli_v = 1'b0;
  assign r1_links[E-1].cli_v = 1'b0;
  assign r1_links[N-1].cli_v = 1'b0;
  assign p1_link.cli_v       = 1'b0;

  // ==========================================================
  // routers, masks indexed by P, W, E, N, S
  // ==========================================================
  mesh_router #(.stub_p(5'b11010)) router0 (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .links     (r0_links),
    .proc_link (p0_link),
    .my_x_i    (x_cord_t'(0)),
    .my_y_i    (y_cord_t'(0))
  );

  mesh_router #(.stub_p(5'b01101)) router1 (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .links     (r1_links),
    .proc_link (p1_link),
    .my_x_i    (x_cord_t'(1)),
    .my_y_i    (y_cord_t'(0))
  );

  mesh_master master0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .link         (p0_link),
    .my_x_i       (x_cord_t'(0)),
    .my_y_i       (y_cord_t'(0)),
    .dest_x_i     (x_cord_t'(1)),
    .dest_y_i     (y_cord_t'(1)),
    .start_i      (start_i),
    .seed_i       (seed_i),
    .reply_v_o    (reply_v_o),
    .reply_addr_o (reply_addr_o),
    .reply_data_o (reply_data_o),
    .finish_o     (finish_o)
  );

  // slave hangs off the south port of node 1
  mesh_slave slave0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .link     (r1_links[S-1]),
    .my_x_i   (x_cord_t'(1)),
    .my_y_i   (y_cord_t'(1))
  );

endmodule

// File: sim/mesh_tb.sv
`timescale 1ns/1ps
`include "mesh_defs.svh"

module mesh_tb import mesh_pkg::*; ();

  localparam int RUN        = `MESH_RUN_WORDS;
  localparam int RUNS       = 4;
  localparam int RST_CYCLES = 16;
  localparam int MAX_CYCLES = RUNS * RUN * 40 + RST_CYCLES;
  localparam int ADDR_SPAN  = 1 << `MESH_ADDR_W;
  localparam logic [ADDR_SPAN-1:0] ALL_SEEN = (ADDR_SPAN'(1) << RUN) - 1;

  logic  clk_i;
  logic  arst_n_i;
  logic  start_i;
  data_t seed_i;
  logic  reply_v_o;
  addr_t reply_addr_o;
  data_t reply_data_o;
  logic  finish_o;

  // reference model state
  data_t                exp_seed;
  logic                 started_q;
  int                   reply_cnt_q;
  logic [ADDR_SPAN-1:0] seen_q;

  int     err_cnt;
  int     test_cnt;
  int     cycle_cnt;
  integer seed_var;

  mesh_top dut0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start_i),
    .seed_i       (seed_i),
    .reply_v_o    (reply_v_o),
    .reply_addr_o (reply_addr_o),
    .reply_data_o (reply_data_o),
    .finish_o     (finish_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  // ============================================================
  // reply bookkeeping, cleared on every start
  // ============================================================
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      started_q   <= 1'b0;
      reply_cnt_q <= 0;
      seen_q      <= '0;
    end else if (start_i) begin
      started_q   <= 1'b1;
      reply_cnt_q <= 0;
      seen_q      <= '0;
    end else if (reply_v_o) begin
      reply_cnt_q          <= reply_cnt_q + 1;
      seen_q[reply_addr_o] <= 1'b1;
    end
  end

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !started_q |-> !finish_o && !reply_v_o)
    else report_failure("output active before the first start");

  a_addr_once: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    reply_v_o |-> reply_addr_o < RUN && !seen_q[reply_addr_o])
    else report_failure($sformatf("reply address %0d out of range or repeated",
                                  $sampled(reply_addr_o)));

  // store k carried seed plus k, so the load of k must return it
  a_reply_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    reply_v_o |-> reply_data_o == exp_seed + data_t'(reply_addr_o))
    else report_failure($sformatf("addr %0d returned %h, expected %h",
                                  $sampled(reply_addr_o), $sampled(reply_data_o),
                                  exp_seed + data_t'($sampled(reply_addr_o))));

  a_count_at_finish: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(finish_o) |-> reply_cnt_q == RUN && seen_q == ALL_SEEN)
    else report_failure("finish raised without one reply per address");

  a_finish_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    finish_o && !start_i |=> finish_o)
    else report_failure("finish dropped without a new start");

  a_no_reply_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    finish_o |-> !reply_v_o)
    else report_failure("reply pulse while finish is high");

  // ============================================================
  // stimulus
  // ============================================================
  task automatic run_write_read(input data_t s);
    @(posedge clk_i);
    #2;
    start_i  = 1'b1;
    seed_i   = s;
    exp_seed = s;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    wait (finish_o);
    // finish has to hold on its own for a while
    repeat (5) @(posedge clk_i);
  endtask

  task automatic log_test_result(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d checks failed", name, err_cnt - errs_before);
  endtask

  initial begin
    data_t s;
    int    errs_before;
    seed_var  = 11;
    err_cnt   = 0;
    test_cnt  = 0;
    cycle_cnt = 0;
    clk_i     = 1'b0;
    arst_n_i  = 1'b0;
    start_i   = 1'b0;
    seed_i    = '0;
    exp_seed  = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    // quiet outputs before any start
    errs_before = err_cnt;
    repeat (10) @(posedge clk_i);
    log_test_result("idle after reset", errs_before);

    // later runs overwrite every word with new data
    for (int r = 0; r < RUNS; r++) begin
      errs_before = err_cnt;
      s = $random(seed_var);
      run_write_read(s);
      log_test_result($sformatf("run %0d seed %h", r, s), errs_before);
    end

    $display("%0d tests run, %0d checks failed", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // ============================================================
  // run limit
  // ============================================================
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run was still busy after %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule
